//--- common/busCtl_defs.svh
`ifndef BUSCTL_DEFS_SVH
`define BUSCTL_DEFS_SVH

// Decoded slice of the 68000 address bus.
// A7..A1 never matter for chip selects, so only A23..A8 come in.
`define ADDR_HI 23 // top address line
`define ADDR_LO 8 // lowest decoded line

// asN synchronizer depth.
// The cycle phase register in busCycleSync counts as the last stage.
`define AS_SYNC_STAGES 2

`endif

//--- common/cpuBusIf.sv
`timescale 1ns/1ps

// one latched CPU bus cycle
interface cpuBusIf;

	cpuBusPkg::cpuAddrT addr; // stable while active
	logic write; // high for a write cycle
	logic active; // level, whole cycle
	logic cycleStart; // one clock at the start
	logic cycleEnd; // one clock after active falls

	modport src (
		output addr,
		output write,
		output active,
		output cycleStart,
		output cycleEnd
	);

	modport sink (
		input addr,
		input write,
		input active,
		input cycleStart,
		input cycleEnd
	);

endinterface

//--- common/cpuBusPkg.sv
`include "busCtl_defs.svh"

package cpuBusPkg;

	// upper CPU address, A23..A8
	typedef logic [`ADDR_HI:`ADDR_LO] cpuAddrT;

	// where busCycleSync is within a CPU bus cycle
	typedef enum logic [1:0] {
		idle = 2'd0, // no strobe seen
		active = 2'd1, // strobe low, address latched
		ending = 2'd2 // one clock after the strobe is released
	} cyclePhaseE;

endpackage

//--- common/selectPkg.sv
package selectPkg;

	// Device selects for one bus cycle, one bit per device.
	// io sits in the MSB and soundWrite in the LSB.
	typedef struct packed {
		logic io; // I/O block: SCSI, SCC, IWM, VIA
		logic ioWrite; // posted write into video RAM
		logic iack; // interrupt acknowledge space
		logic rom; // ROM, incl. overlay at 0
		logic romHigh; // ROM at 0x4xxxxx
		logic ram; // main RAM
		logic ramLow; // lower 4 MB window
		logic soundWrite; // write into sound buffer
	} selectT;

endpackage

//--- decode/addrDecoder.sv
`timescale 1ns/1ps

module addrDecoder (
	input logic CLK,
	input logic arstN,
	input logic cpuResetN,
	cpuBusIf.sink bus,
	output selectPkg::selectT sel
);
	import selectPkg::*;

	logic overlay; // ROM also at 0, RAM hidden
	logic romHighSeen; // this cycle hit 0x4xxxxx
	logic [3:0] topNib; // A23..A20
	logic [3:0] page; // A15..A12
	logic [3:0] subPage; // A11..A8
	logic vidSpaceWr; // write somewhere in 3Fxxxx
	logic vidPage; // page lies in the video write window
	logic sndPage; // page lies in the sound buffer
	selectT dec;

	assign topNib = bus.addr[23:20];
	assign page = bus.addr[15:12];
	assign subPage = bus.addr[11:8];
	assign vidSpaceWr = bus.write && (bus.addr[23:16] == 8'h3F);

	// Video write window inside 3Fxxxx.
	// The holes in pages 2, 7 and A are plain RAM and are not posted.
	always_comb begin
		case (page)
			4'h2: vidPage = (subPage >= 4'h7);
			4'h3,
			4'h4,
			4'h5,
			4'h6: vidPage = 1'b1;
			4'h7: vidPage = (subPage <= 4'hC);
			4'hA: vidPage = (subPage >= 4'h1 && subPage <= 4'h3) || (subPage >= 4'h7);
			4'hB,
			4'hC,
			4'hD,
			4'hE,
			4'hF: vidPage = 1'b1;
			default: vidPage = 1'b0;
		endcase
	end

	// sound buffer sits at FD..FF and A1..A3
	assign sndPage = ((page == 4'hF) && (subPage >= 4'hD)) ||
		((page == 4'hA) && (subPage >= 4'h1) && (subPage <= 4'h3));

	always_comb begin
		dec.romHigh = (topNib == 4'h4);
		dec.rom = dec.romHigh || ((topNib == 4'h0) && overlay);
		dec.ramLow = (bus.addr[23:22] == 2'b00);
		dec.ram = dec.ramLow && !overlay;
		dec.iack = (bus.addr[23:16] == 8'hFF);
		dec.ioWrite = vidSpaceWr && vidPage;
		dec.soundWrite = vidSpaceWr && sndPage;
		dec.io = (topNib >= 4'h5) || // SCSI up to IACK
			(dec.romHigh && overlay) || // ROM once, through the slow path
			dec.ioWrite;
	end

	assign sel = dec;

	// The overlay leaves after the first finished 0x4xxxxx cycle.
	// A CPU reset between cycles brings it back.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			overlay <= 1'b1;
			romHighSeen <= 1'b0;
		end else begin
			if (bus.cycleStart) begin
				romHighSeen <= dec.romHigh;
			end else if (bus.cycleEnd) begin
				romHighSeen <= 1'b0;
			end
			if (!bus.active && !cpuResetN) begin
				overlay <= 1'b1;
			end else if (bus.cycleEnd && romHighSeen) begin
				overlay <= 1'b0;
			end
		end
	end

	soundInVideo: assert property (@(posedge CLK) disable iff (!arstN)
		bus.active && dec.soundWrite |-> dec.ioWrite);

endmodule

//--- hw/busCycleSync.sv
`timescale 1ns/1ps
`include "busCtl_defs.svh"

module busCycleSync (
	input logic CLK,
	input logic arstN,
	input cpuBusPkg::cpuAddrT addr,
	input logic asN,
	input logic weN,
	cpuBusIf.src bus
);
	import cpuBusPkg::*;

	logic [`AS_SYNC_STAGES-2:0] asSyncN; // leading stages, phase is the last
	logic asLowNext; // strobe as it enters the phase register
	cyclePhaseE phase;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			asSyncN <= '1;
		end else begin
			asSyncN[0] <= asN;
			for (int i = 1; i < `AS_SYNC_STAGES - 1; i++) begin
				asSyncN[i] <= asSyncN[i-1];
			end
		end
	end

	assign asLowNext = !asSyncN[`AS_SYNC_STAGES-2];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			phase <= idle;
			bus.cycleStart <= 1'b0;
		end else begin
			bus.cycleStart <= 1'b0;
			case (phase)
				idle: if (asLowNext) begin
					phase <= active;
					bus.cycleStart <= 1'b1;
				end
				active: if (!asLowNext) phase <= ending;
				ending: phase <= idle; // gap of one clock before the next cycle
				default: phase <= idle;
			endcase
		end
	end

	// address and direction are frozen for the whole cycle
	always_ff @(posedge CLK) begin
		if (phase == idle && asLowNext) begin
			bus.addr <= addr;
			bus.write <= !weN;
		end
	end

	assign bus.active = (phase == active);
	assign bus.cycleEnd = (phase == ending);

	startEndExclusive: assert property (@(posedge CLK) disable iff (!arstN)
		!(bus.cycleStart && bus.cycleEnd));

endmodule

//--- hw/macBusCtl.sv
`timescale 1ns/1ps
`include "busCtl_defs.svh"

module macBusCtl (
	input logic CLK,
	input logic arstN,
	input logic cpuResetN, // CPU reset line, restores the overlay
	input logic asN,
	input logic weN,
	input logic [`ADDR_HI:`ADDR_LO] addr,
	output logic ioSel,
	output logic ioWriteSel,
	output logic iackSel,
	output logic romSel,
	output logic romHighSel,
	output logic ramSel,
	output logic ramLowSel,
	output logic soundWriteSel
);
	import selectPkg::*;

	selectT decSel; // combinational decode
	selectT selOut; // registered selects

	cpuBusIf bus ();

	busCycleSync u_busCycleSync (
		.CLK (CLK),
		.arstN (arstN),
		.addr (addr),
		.asN (asN),
		.weN (weN),
		.bus (bus.src)
	);

	addrDecoder u_addrDecoder (
		.CLK (CLK),
		.arstN (arstN),
		.cpuResetN (cpuResetN),
		.bus (bus.sink),
		.sel (decSel)
	);

	selectDriver u_selectDriver (
		.CLK (CLK),
		.arstN (arstN),
		.bus (bus.sink),
		.sel (decSel),
		.selOut (selOut)
	);

	assign ioSel = selOut.io;
	assign ioWriteSel = selOut.ioWrite;
	assign iackSel = selOut.iack;
	assign romSel = selOut.rom;
	assign romHighSel = selOut.romHigh;
	assign ramSel = selOut.ram;
	assign ramLowSel = selOut.ramLow;
	assign soundWriteSel = selOut.soundWrite;

endmodule

//--- hw/selectDriver.sv
`timescale 1ns/1ps

module selectDriver (
	input logic CLK,
	input logic arstN,
	cpuBusIf.sink bus,
	input selectPkg::selectT sel,
	output selectPkg::selectT selOut
);

	// Decode ripples while the latched address and overlay settle.
	// Registering here keeps those glitches off the device pins.
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			selOut <= '0;
		end else if (bus.active) begin
			selOut <= sel;
		end else begin
			selOut <= '0; // idle between cycles
		end
	end

	romRamExclusive: assert property (@(posedge CLK) disable iff (!arstN)
		!(selOut.rom && selOut.ram));

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f src.f --top-module tbMacBusCtl --Mdir obj_dir &&
./obj_dir/VtbMacBusCtl > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "=== PASS ===" sim.log && echo "run.sh: simulation passed" ||
	{ echo "run.sh: simulation failed"; exit 1; }

//--- src.f
+incdir+common
common/cpuBusPkg.sv
common/selectPkg.sv
common/cpuBusIf.sv
hw/busCycleSync.sv
decode/addrDecoder.sv
hw/selectDriver.sv
hw/macBusCtl.sv
testbench/tbMacBusCtl.sv

//--- testbench/tbMacBusCtl.sv
`timescale 1ns/1ps
`include "busCtl_defs.svh"

module tbMacBusCtl;
	import cpuBusPkg::*;
	import selectPkg::*;

	logic CLK;
	logic arstN;
	logic cpuResetN;
	logic asN;
	logic weN;
	logic [`ADDR_HI:`ADDR_LO] addr;
	logic ioSel;
	logic ioWriteSel;
	logic iackSel;
	logic romSel;
	logic romHighSel;
	logic ramSel;
	logic ramLowSel;
	logic soundWriteSel;

	int errCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int timeoutCount = 0;
	logic overlayModel = 1'b1; // set by reset
	cyclePhaseE busPhase = idle; // what the stimulus is doing

	macBusCtl u_macBusCtl (
		.CLK (CLK),
		.arstN (arstN),
		.cpuResetN (cpuResetN),
		.asN (asN),
		.weN (weN),
		.addr (addr),
		.ioSel (ioSel),
		.ioWriteSel (ioWriteSel),
		.iackSel (iackSel),
		.romSel (romSel),
		.romHighSel (romHighSel),
		.ramSel (ramSel),
		.ramLowSel (ramLowSel),
		.soundWriteSel (soundWriteSel)
	);

	always #4 CLK = ~CLK;

	// page byte A15..A8 inside 3Fxxxx
	function automatic logic inVideoWindow(input logic [7:0] p);
		return (p >= 8'h27 && p <= 8'h7C) || (p >= 8'hA1 && p <= 8'hA3) || (p >= 8'hA7);
	endfunction

	function automatic logic inSoundBuffer(input logic [7:0] p);
		return (p >= 8'hFD) || (p >= 8'hA1 && p <= 8'hA3);
	endfunction

	function automatic selectT expectedSelects(input cpuAddrT a, input logic wr, input logic ov);
		selectT s;
		logic inSpace;
		s = '0;
		inSpace = wr && (a[23:16] == 8'h3F);
		s.romHigh = (a[23:20] == 4'h4);
		s.rom = s.romHigh || (ov && a[23:20] == 4'h0);
		s.ramLow = (a[23:22] == 2'b00);
		s.ram = s.ramLow && !ov;
		s.iack = (a[23:16] == 8'hFF);
		s.ioWrite = inSpace && inVideoWindow(a[15:8]);
		s.soundWrite = inSpace && inSoundBuffer(a[15:8]);
		s.io = (a[23:20] >= 4'h5) || (s.romHigh && ov) || s.ioWrite;
		return s;
	endfunction

	function automatic selectT currentSelects();
		return {ioSel, ioWriteSel, iackSel, romSel, romHighSel, ramSel, ramLowSel, soundWriteSel};
	endfunction

	task automatic compareSelect(input string name, input logic got, input logic exp,
			input cpuAddrT a);
		checkCount++;
		assert (got === exp) else begin
			errCount++;
			$display("Mismatch %s: got 0x%0h expected 0x%0h (addr 0x%04h)", name, got, exp, a);
		end
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("Timeout: %s", what);
	endtask

	// nothing may be selected while no cycle runs
	always @(posedge CLK) begin
		if (arstN && busPhase == idle) begin
			assert (currentSelects() == '0) else begin
				errCount++;
				$display("Mismatch selects between cycles: got 0x%02h expected 0x00",
					currentSelects());
			end
		end
	end

	task automatic runCycle(input cpuAddrT a, input logic wr);
		selectT exp;
		selectT got;
		int waited;
		bit done;
		if (timeoutCount != 0) return;
		exp = expectedSelects(a, wr, overlayModel);
		cycleCount++;
		@(negedge CLK);
		addr = a;
		weN = !wr;
		asN = 1'b0;
		busPhase = active;
		waited = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge CLK);
			waited++;
			got = currentSelects();
			if (got != '0 || (exp == '0 && waited >= 5)) begin
				done = 1'b1;
			end else if (waited >= 20) begin
				reportTimeout("no select went high within 20 cycles of the strobe");
				return;
			end
		end
		compareSelect("ioSel", got.io, exp.io, a);
		compareSelect("ioWriteSel", got.ioWrite, exp.ioWrite, a);
		compareSelect("iackSel", got.iack, exp.iack, a);
		compareSelect("romSel", got.rom, exp.rom, a);
		compareSelect("romHighSel", got.romHigh, exp.romHigh, a);
		compareSelect("ramSel", got.ram, exp.ram, a);
		compareSelect("ramLowSel", got.ramLow, exp.ramLow, a);
		compareSelect("soundWriteSel", got.soundWrite, exp.soundWrite, a);
		while (waited < 6) begin // strobe stays low for 6 cycles
			@(negedge CLK);
			waited++;
			assert (currentSelects() == got) else begin
				errCount++;
				$display("Mismatch selects during cycle: got 0x%02h expected 0x%02h",
					currentSelects(), got);
			end
		end
		asN = 1'b1;
		busPhase = ending;
		waited = 0;
		while (currentSelects() != '0) begin
			if (waited >= 20) begin
				reportTimeout("selects still high 20 cycles after the strobe was released");
				return;
			end
			@(negedge CLK);
			waited++;
		end
		if (exp.romHigh) overlayModel = 1'b0; // first 0x4xxxxx cycle drops the overlay
		busPhase = idle;
	endtask

	task automatic pulseCpuReset();
		@(negedge CLK);
		cpuResetN = 1'b0;
		repeat (2) @(negedge CLK);
		cpuResetN = 1'b1;
		overlayModel = 1'b1;
	endtask

	// boot map, its removal, then the normal map
	task automatic overlaySequence();
		int unsigned r;
		r = $urandom;
		runCycle({4'h0, r[11:0]}, 1'b0);
		runCycle({4'h4, r[23:12]}, 1'b0);
		runCycle({4'h0, r[11:0]}, 1'b1);
		runCycle({4'h4, r[23:12]}, 1'b0);
	endtask

	initial begin
		int unsigned r;
		int unsigned n;
		cpuAddrT a;
		CLK = 1'b0;
		arstN = 1'b0;
		cpuResetN = 1'b1;
		asN = 1'b1;
		weN = 1'b1;
		addr = '0;
		void'($urandom(7));
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1;

		overlaySequence();
		repeat (48) begin // video window, writes then reads
			r = $urandom;
			a = {8'h3F, r[7:0]};
			runCycle(a, 1'b1);
			runCycle(a, 1'b0);
		end
		for (int p = 0; p < 256; p++) begin // every page once, sound buffer edges
			a = {8'h3F, p[7:0]};
			runCycle(a, 1'b1);
		end
		repeat (40) begin // I/O space
			r = $urandom;
			n = 5 + (r >> 16) % 11;
			runCycle({n[3:0], r[11:0]}, r[12]);
		end
		repeat (8) begin
			r = $urandom;
			runCycle({8'hFF, r[7:0]}, r[8]);
		end
		pulseCpuReset();
		overlaySequence();
		repeat (150) begin // anything goes
			r = $urandom;
			if (r[31:28] == 4'h0) pulseCpuReset();
			runCycle(r[15:0], r[16]);
		end

		$display("cycles=%0d checks=%0d errors=%0d timeouts=%0d",
			cycleCount, checkCount, errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule
